// File: Makefile
# Verilator build and run for the floppy controller testbench
LOG = sim.log

compile:
	verilator --binary --timing --assert -f vlog.f --top-module fdcTb -Mdir obj_dir -o fdcSim

run: compile
	./obj_dir/fdcSim +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: compile run clean

// File: source/commandSequencer.sv
/*
 * Command sequencer.
 * Holds the host registers, decodes Type I and Force Interrupt commands
 * and runs the restore, seek and step sequences with head load control.
 */
`timescale 1ns/1ns
`default_nettype none

module commandSequencer (
	input logic iCLK,
	input logic rstN,
	input logic wrStrobe,
	input fdcRegsPkg::regAddrT adr,
	input logic [7:0] dataIn,
	input logic tr00Sync,
	input fdcTimingPkg::idxCountT idleIndexCount,
	input logic stepActive,
	input fdcTimingPkg::rateTicksT delayCount,
	output logic stepStart,
	output logic delayStart,
	output fdcTimingPkg::rateTicksT delayTicks,
	output logic busy,
	output logic cmdActive,
	output logic hld,
	output logic dirc,
	output logic [7:0] cmdReg,
	output logic [7:0] trackReg,
	output logic [7:0] sectorReg,
	output logic [7:0] dataReg,
	output logic cmdDone,
	output logic cmdAccepted,
	output logic forceIntPulse
);
	import fdcRegsPkg::*;
	import fdcTimingPkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_RESTORE,
		S_COMPARE,
		S_DELAY,
		S_UPDATE,
		S_PULSE,
		S_DONE
	} stageT;

	stageT stage;
	logic isRestore;
	logic isSeek;
	logic isStepIn;
	logic isStepOut;
	logic trackUpdate;
	logic seekDir;
	logic startDir;
	logic typeIWrite;
	logic forceIntWrite;
	rateTicksT rateTicks;

	assign isRestore = cmdReg[7:4] == CMD_RESTORE[7:4];
	assign isSeek = cmdReg[7:4] == CMD_SEEK[7:4];
	assign isStepIn = cmdReg[7:5] == CMD_STEP_IN[7:5];
	assign isStepOut = cmdReg[7:5] == CMD_STEP_OUT[7:5];
	assign trackUpdate = isRestore | isSeek | cmdReg[BIT_UPDATE];
	assign seekDir = trackReg < dataReg;	// 1 steps in
	assign startDir = isStepIn ? 1'b1 : (isStepOut ? 1'b0 : dirc);

	// Type II and III codes are not decoded and leave the sequencer alone
	assign typeIWrite = wrStrobe && adr == ADDR_CMD_STATUS && !dataIn[7];
	assign forceIntWrite = wrStrobe && adr == ADDR_CMD_STATUS &&
		dataIn[7:4] == CMD_FORCE_INT[7:4];

	assign cmdActive = stage != S_IDLE;

	always_comb begin
		case (cmdReg[1:0])
			2'b00: rateTicks = RATE_TICKS_6;
			2'b01: rateTicks = RATE_TICKS_12;
			2'b10: rateTicks = RATE_TICKS_20;
			default: rateTicks = RATE_TICKS_30;
		endcase
	end

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			stage <= S_START;	// Power-on Restore
			cmdReg <= CMD_RESET_DEFAULT;
			trackReg <= '0;
			sectorReg <= SECTOR_RESET_VALUE;
			dataReg <= '0;
			busy <= 1'b0;
			hld <= 1'b0;
			dirc <= 1'b0;
			stepStart <= 1'b0;
			delayStart <= 1'b0;
			delayTicks <= '0;
			cmdDone <= 1'b0;
			cmdAccepted <= 1'b0;
			forceIntPulse <= 1'b0;
		end else begin
			stepStart <= 1'b0;
			delayStart <= 1'b0;
			cmdDone <= 1'b0;
			cmdAccepted <= 1'b0;
			forceIntPulse <= 1'b0;

			if (typeIWrite || forceIntWrite) begin
				cmdReg <= dataIn;
				cmdAccepted <= 1'b1;	// Aborts whatever is running
				if (forceIntWrite) begin
					stage <= S_IDLE;
					busy <= 1'b0;
					forceIntPulse <= dataIn[3:0] != 4'd0;
				end else begin
					stage <= S_START;
				end
			end else begin
				case (stage)
					S_IDLE: begin
						if (hld && idleIndexCount == IDLE_UNLOAD_INDEX) begin
							hld <= 1'b0;
						end
					end
					S_START: begin
						busy <= 1'b1;
						hld <= cmdReg[BIT_HEAD_LOAD];
						if (isRestore) begin
							stage <= S_RESTORE;
						end else if (isSeek) begin
							stage <= S_COMPARE;
						end else begin
							dirc <= startDir;
							delayStart <= 1'b1;
							delayTicks <= (startDir != dirc) ? SETTLE_TICKS : rateTicks;
							stage <= S_DELAY;
						end
					end
					S_RESTORE: begin
						trackReg <= 8'hFF;
						dataReg <= '0;
						stage <= S_COMPARE;
					end
					S_COMPARE: begin
						if (trackReg == dataReg) begin
							stage <= S_DONE;
						end else begin
							dirc <= seekDir;
							delayStart <= 1'b1;
							delayTicks <= (seekDir != dirc) ? SETTLE_TICKS : rateTicks;
							stage <= S_DELAY;
						end
					end
					S_DELAY: begin
						if (!delayStart && delayCount == '0) begin
							stage <= S_UPDATE;
						end
					end
					S_UPDATE: begin
						if (!dirc && tr00Sync) begin	// Head already on track 0
							trackReg <= '0;
							stage <= S_DONE;
						end else begin
							if (trackUpdate) begin
								trackReg <= dirc ? trackReg + 8'd1 : trackReg - 8'd1;
							end
							stepStart <= 1'b1;
							stage <= S_PULSE;
						end
					end
					S_PULSE: begin
						if (!stepActive) begin
							stage <= (isRestore || isSeek) ? S_COMPARE : S_DONE;
						end
					end
					default: begin	// S_DONE
						busy <= 1'b0;
						cmdDone <= 1'b1;
						stage <= S_IDLE;
					end
				endcase
			end

			// Host writes win over sequencer updates
			if (wrStrobe) begin
				case (adr)
					ADDR_TRACK: trackReg <= dataIn;
					ADDR_SECTOR: sectorReg <= dataIn;
					ADDR_DATA: dataReg <= dataIn;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/driveSync.sv
/*
 * Drive and host input synchronizer.
 * Brings the asynchronous lines into the clock domain, makes the write
 * strobe and the index pulse, and counts index pulses while idle.
 */
`timescale 1ns/1ns
`default_nettype none

module driveSync (
	input logic iCLK,
	input logic rstN,
	input logic wrEn,
	input logic ip,
	input logic hrdy,
	input logic tr00,
	input logic wrpt,
	input logic cmdActive,
	output logic wrStrobe,
	output logic indexPulse,
	output logic hrdySync,
	output logic tr00Sync,
	output logic wrptSync,
	output logic ipLevel,
	output fdcTimingPkg::idxCountT idleIndexCount
);
	import fdcTimingPkg::*;

	logic [4:0] metaReg;	// wrEn, ip, hrdy, tr00, wrpt
	logic [4:0] syncReg;
	logic wrEnLast;
	logic ipLast;

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			metaReg <= '0;
			syncReg <= '0;
			wrEnLast <= 1'b0;
			ipLast <= 1'b0;
		end else begin
			metaReg <= {wrEn, ip, hrdy, tr00, wrpt};
			syncReg <= metaReg;
			wrEnLast <= syncReg[4];
			ipLast <= syncReg[3];
		end
	end

	assign wrStrobe = syncReg[4] & ~wrEnLast;	// Rising edge of write enable
	assign indexPulse = syncReg[3] & ~ipLast;
	assign ipLevel = syncReg[3];
	assign hrdySync = syncReg[2];
	assign tr00Sync = syncReg[1];
	assign wrptSync = syncReg[0];

	// Saturates so the unload compare holds until the next command
	always_ff @(posedge iCLK) begin
		if (!rstN || cmdActive) begin
			idleIndexCount <= '0;
		end else if (indexPulse && idleIndexCount != IDLE_UNLOAD_INDEX) begin
			idleIndexCount <= idleIndexCount + 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: source/fdcRegsPkg.sv
/*
 * Floppy controller register map.
 * Host register addresses, Type I command codes and field positions,
 * and status bit positions of the Type I status byte.
 */
`default_nettype none

package fdcRegsPkg;

	typedef logic [1:0] regAddrT;

	localparam regAddrT ADDR_CMD_STATUS = 2'd0;	// Write command, read status
	localparam regAddrT ADDR_TRACK = 2'd1;
	localparam regAddrT ADDR_SECTOR = 2'd2;
	localparam regAddrT ADDR_DATA = 2'd3;

	// Base codes, low bits carry flags and rate
	localparam logic [7:0] CMD_RESTORE = 8'h00;
	localparam logic [7:0] CMD_SEEK = 8'h10;
	localparam logic [7:0] CMD_STEP = 8'h20;
	localparam logic [7:0] CMD_STEP_IN = 8'h40;
	localparam logic [7:0] CMD_STEP_OUT = 8'h60;
	localparam logic [7:0] CMD_FORCE_INT = 8'hD0;
	localparam logic [7:0] CMD_RESET_DEFAULT = 8'h03;	// Restore at slowest rate

	localparam int BIT_UPDATE = 4;	// Track update on step commands
	localparam int BIT_HEAD_LOAD = 3;
	localparam int BIT_VERIFY = 2;

	localparam int STA_BUSY = 0;
	localparam int STA_INDEX = 1;
	localparam int STA_TRACK0 = 2;
	localparam int STA_HEAD_LOADED = 5;
	localparam int STA_WRPROT = 6;
	localparam int STA_NOT_READY = 7;

	localparam logic [7:0] SECTOR_RESET_VALUE = 8'd1;

endpackage

`default_nettype wire

// File: source/fdcTimingPkg.sv
/*
 * Floppy controller timing constants.
 * Step pulse width, delay prescaler, stepping rates and index limits.
 */
`default_nettype none

package fdcTimingPkg;

	localparam int STEP_PULSE_CYCLES = 15;
	localparam int PRESCALE_BITS = 11;	// One delay tick is 2048 clocks

	typedef logic [7:0] rateTicksT;

	// Stepping rates by command bits 1:0
	localparam rateTicksT RATE_TICKS_6 = 8'd47;
	localparam rateTicksT RATE_TICKS_12 = 8'd94;
	localparam rateTicksT RATE_TICKS_20 = 8'd156;
	localparam rateTicksT RATE_TICKS_30 = 8'd234;

	localparam rateTicksT SETTLE_TICKS = 8'd3;	// After a direction change

	typedef logic [3:0] idxCountT;

	localparam idxCountT IDLE_UNLOAD_INDEX = 4'd15;

endpackage

`default_nettype wire

// File: source/fdcTop.sv
/*
 * Floppy controller top level.
 * Input synchronizer, step timer, command sequencer and host status.
 */
`timescale 1ns/1ns
`default_nettype none

module fdcTop (
	input logic iCLK,
	input logic rstN,
	input logic wrEn,
	input fdcRegsPkg::regAddrT adr,
	input logic [7:0] dataIn,
	output logic [7:0] dataOut,
	input logic statusRead,
	output logic step,
	output logic dirc,
	output logic hld,
	input logic hrdy,
	input logic tr00,
	input logic ip,
	input logic wrpt,
	output logic intrq
);
	import fdcTimingPkg::*;

	logic wrStrobe;
	logic hrdySync;
	logic tr00Sync;
	logic wrptSync;
	logic ipLevel;
	idxCountT idleIndexCount;
	logic stepStart;
	logic delayStart;
	rateTicksT delayTicks;
	rateTicksT delayCount;
	logic stepActive;
	logic busy;
	logic cmdActive;
	logic [7:0] trackReg;
	logic [7:0] sectorReg;
	logic [7:0] dataReg;
	logic cmdDone;
	logic cmdAccepted;
	logic forceIntPulse;

	driveSync uSync (
		.iCLK(iCLK), .rstN(rstN), .wrEn(wrEn), .ip(ip), .hrdy(hrdy), .tr00(tr00),
		.wrpt(wrpt), .cmdActive(cmdActive), .wrStrobe(wrStrobe), .indexPulse(),
		.hrdySync(hrdySync), .tr00Sync(tr00Sync), .wrptSync(wrptSync), .ipLevel(ipLevel),
		.idleIndexCount(idleIndexCount)
	);

	stepTimer uTimer (
		.iCLK(iCLK), .rstN(rstN), .stepStart(stepStart), .delayStart(delayStart),
		.delayTicks(delayTicks), .step(step), .stepActive(stepActive),
		.delayCount(delayCount)
	);

	commandSequencer uSeq (
		.iCLK(iCLK), .rstN(rstN), .wrStrobe(wrStrobe), .adr(adr), .dataIn(dataIn),
		.tr00Sync(tr00Sync), .idleIndexCount(idleIndexCount), .stepActive(stepActive),
		.delayCount(delayCount), .stepStart(stepStart), .delayStart(delayStart),
		.delayTicks(delayTicks), .busy(busy), .cmdActive(cmdActive), .hld(hld),
		.dirc(dirc), .cmdReg(), .trackReg(trackReg), .sectorReg(sectorReg),
		.dataReg(dataReg), .cmdDone(cmdDone), .cmdAccepted(cmdAccepted),
		.forceIntPulse(forceIntPulse)
	);

	hostStatus uStatus (
		.iCLK(iCLK), .rstN(rstN), .adr(adr), .statusRead(statusRead), .busy(busy),
		.hld(hld), .hrdySync(hrdySync), .ipLevel(ipLevel), .tr00Sync(tr00Sync),
		.wrptSync(wrptSync), .trackReg(trackReg), .sectorReg(sectorReg),
		.dataReg(dataReg), .cmdDone(cmdDone), .cmdAccepted(cmdAccepted),
		.forceIntPulse(forceIntPulse), .dataOut(dataOut), .intrq(intrq)
	);

endmodule

`default_nettype wire

// File: source/hostStatus.sv
/*
 * Host read side.
 * Builds the Type I status byte, selects the register to read and
 * keeps the INTRQ line.
 */
`timescale 1ns/1ns
`default_nettype none

module hostStatus (
	input logic iCLK,
	input logic rstN,
	input fdcRegsPkg::regAddrT adr,
	input logic statusRead,
	input logic busy,
	input logic hld,
	input logic hrdySync,
	input logic ipLevel,
	input logic tr00Sync,
	input logic wrptSync,
	input logic [7:0] trackReg,
	input logic [7:0] sectorReg,
	input logic [7:0] dataReg,
	input logic cmdDone,
	input logic cmdAccepted,
	input logic forceIntPulse,
	output logic [7:0] dataOut,
	output logic intrq
);
	import fdcRegsPkg::*;

	logic [7:0] status;
	logic readMeta;
	logic readSync;
	logic readLast;
	logic readClear;

	always_comb begin
		status = '0;	// Seek and CRC error never set
		status[STA_BUSY] = busy;
		status[STA_INDEX] = ~ipLevel;
		status[STA_TRACK0] = tr00Sync;
		status[STA_HEAD_LOADED] = hld & hrdySync;
		status[STA_WRPROT] = wrptSync;
		status[STA_NOT_READY] = 1'b0;	// Drive always ready
	end

	always_comb begin
		case (adr)
			ADDR_CMD_STATUS: dataOut = status;
			ADDR_TRACK: dataOut = trackReg;
			ADDR_SECTOR: dataOut = sectorReg;
			default: dataOut = dataReg;
		endcase
	end

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			readMeta <= 1'b0;
			readSync <= 1'b0;
			readLast <= 1'b0;
		end else begin
			readMeta <= statusRead;
			readSync <= readMeta;
			readLast <= readSync;
		end
	end

	assign readClear = readSync & ~readLast;

	// A set in the same cycle as a clear wins
	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			intrq <= 1'b0;
		end else if (cmdDone || forceIntPulse) begin
			intrq <= 1'b1;
		end else if (cmdAccepted || readClear) begin
			intrq <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/stepTimer.sv
/*
 * Step and delay timer.
 * A prescaler divides the clock into delay ticks for the stepping rate
 * and settle delays, and a short counter shapes the step pulse.
 */
`timescale 1ns/1ns
`default_nettype none

module stepTimer (
	input logic iCLK,
	input logic rstN,
	input logic stepStart,
	input logic delayStart,
	input fdcTimingPkg::rateTicksT delayTicks,
	output logic step,
	output logic stepActive,
	output fdcTimingPkg::rateTicksT delayCount
);
	import fdcTimingPkg::*;

	logic [PRESCALE_BITS-1:0] prescale;
	logic prescaleWrap;
	logic [3:0] stepCount;	// Wide enough for the 15 cycle pulse

	assign prescaleWrap = &prescale;

	// Restarted by either start so a tick count is a full tick long
	always_ff @(posedge iCLK) begin
		if (!rstN || stepStart || delayStart) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			delayCount <= '0;
		end else if (delayStart) begin
			delayCount <= delayTicks;
		end else if (prescaleWrap && delayCount != '0) begin
			delayCount <= delayCount - 8'd1;
		end
	end

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			stepCount <= '0;
		end else if (stepStart) begin
			stepCount <= 4'(STEP_PULSE_CYCLES);
		end else if (stepCount != '0) begin
			stepCount <= stepCount - 4'd1;
		end
	end

	assign step = stepCount != '0;
	assign stepActive = stepStart | step;	// Covers the cycle before the load

endmodule

`default_nettype wire

// File: tests/fdcTb.sv
/*
 * Testbench for the floppy controller command and stepper section.
 * Directed reset, register, Type I and interrupt tests with a step monitor.
 */
`timescale 1ns/1ns
`default_nettype none

module fdcTb;
	import fdcRegsPkg::*;
	import fdcTimingPkg::*;

	localparam int STEP_BUDGET = 12;	// Delays over all tests after the reset Restore
	localparam int CYCLE_LIMIT = (int'(RATE_TICKS_30) + STEP_BUDGET *
		(int'(RATE_TICKS_6) + int'(SETTLE_TICKS))) * (2 ** PRESCALE_BITS) + 50000;

	logic iCLK = 1'b0;
	logic rstN;
	logic wrEn;
	regAddrT adr;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic statusRead;
	logic step;
	logic dirc;
	logic hld;
	logic hrdy;
	logic tr00;
	logic ip;
	logic wrpt;
	logic intrq;
	int errorCount = 0;
	int checkTotal = 0;
	int assertFails;
	int cycleCount = 0;
	int stepTotal = 0;
	int stepInTotal = 0;	// Pulses seen with dirc high

	fdcTop UUT (
		.iCLK(iCLK), .rstN(rstN), .wrEn(wrEn), .adr(adr), .dataIn(dataIn),
		.dataOut(dataOut), .statusRead(statusRead), .step(step), .dirc(dirc), .hld(hld),
		.hrdy(hrdy), .tr00(tr00), .ip(ip), .wrpt(wrpt), .intrq(intrq)
	);

	bind fdcTop fdcTop_props uProps (
		.iCLK(iCLK), .rstN(rstN), .step(step), .busy(busy), .intrq(intrq)
	);

	always #10 iCLK = ~iCLK;

	always @(posedge step) begin
		stepTotal = stepTotal + 1;
		if (dirc) begin
			stepInTotal = stepInTotal + 1;
		end
	end

	always @(posedge iCLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Run did not finish within %0d cycles, %0d errors so far",
				cycleCount, errorCount);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic checkByte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checkTotal++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkTotal++;
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic checkPulses(input string name, input int got, input int exp);
		checkTotal++;
		if (got != exp) begin
			errorCount++;
			$display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	// Type I status byte as the host should see it
	function automatic logic [7:0] statusByte(input logic bsy, input logic idx,
		input logic tr0, input logic hl, input logic wp);
		logic [7:0] s;
		s = '0;
		s[STA_BUSY] = bsy;
		s[STA_INDEX] = idx;
		s[STA_TRACK0] = tr0;
		s[STA_HEAD_LOADED] = hl;
		s[STA_WRPROT] = wp;
		return s;
	endfunction

	task automatic writeReg(input regAddrT a, input logic [7:0] d);
		@(posedge iCLK);
		#2;
		adr = a;
		dataIn = d;
		wrEn = 1'b1;
		repeat (5) @(posedge iCLK);	// Held long enough for the strobe
		#2;
		wrEn = 1'b0;
		repeat (3) @(posedge iCLK);
	endtask

	task automatic readReg(input regAddrT a, output logic [7:0] v);
		@(posedge iCLK);
		#2;
		adr = a;
		#1;
		v = dataOut;
	endtask

	task automatic waitIdle;
		@(posedge iCLK);
		#2;
		adr = ADDR_CMD_STATUS;
		#1;
		while (dataOut[STA_BUSY]) begin
			@(posedge iCLK);
			#3;
		end
	endtask

	// Busy just fell, so INTRQ is due on the next edge
	task automatic finishCommand;
		waitIdle();
		@(posedge iCLK);
		#3;
		checkBit("intrq at end of command", intrq, 1'b1);
	endtask

	task automatic waitPulses(input int base, input int n);
		while (stepTotal - base < n || step) begin
			@(posedge iCLK);
			#3;
		end
	endtask

	task automatic readStatus;
		@(posedge iCLK);
		#2;
		statusRead = 1'b1;
		repeat (4) @(posedge iCLK);
		#2;
		statusRead = 1'b0;
	endtask

	task automatic indexPulse;
		@(posedge iCLK);
		#2;
		ip = 1'b1;
		repeat (4) @(posedge iCLK);
		#2;
		ip = 1'b0;
		repeat (4) @(posedge iCLK);
	endtask

	task automatic testResetRestore;
		logic [7:0] v;
		rstN = 1'b0;
		repeat (5) @(posedge iCLK);
		#2;
		rstN = 1'b1;
		repeat (3) @(posedge iCLK);
		finishCommand();
		checkPulses("step pulses after reset", stepTotal, 0);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'h00);
		readReg(ADDR_SECTOR, v);
		checkByte("sectorReg", v, SECTOR_RESET_VALUE);
		readReg(ADDR_CMD_STATUS, v);
		checkByte("status", v, statusByte(1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
		@(posedge iCLK);
		#2;
		ip = 1'b1;
		wrpt = 1'b0;
		tr00 = 1'b0;
		repeat (4) @(posedge iCLK);
		readReg(ADDR_CMD_STATUS, v);
		checkByte("status", v, statusByte(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		@(posedge iCLK);
		#2;
		ip = 1'b0;
		tr00 = 1'b1;
		repeat (4) @(posedge iCLK);
	endtask

	task automatic testRegisters;
		logic [7:0] v;
		logic [7:0] want;
		for (int a = 1; a < 4; a++) begin
			want = 8'($urandom);
			writeReg(regAddrT'(a), want);
			readReg(regAddrT'(a), v);
			checkByte($sformatf("register at address %0d", a), v, want);
		end
	endtask

	task automatic testSeek;
		int base;
		int baseIn;
		logic [7:0] v;
		@(posedge iCLK);
		#2;
		tr00 = 1'b0;	// Head is away from track 0
		writeReg(ADDR_TRACK, 8'd2);
		writeReg(ADDR_DATA, 8'd5);
		base = stepTotal;
		baseIn = stepInTotal;
		writeReg(ADDR_CMD_STATUS, CMD_SEEK);
		finishCommand();
		checkPulses("seek in step pulses", stepTotal - base, 3);
		checkPulses("seek in pulses with dirc high", stepInTotal - baseIn, 3);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'd5);
		writeReg(ADDR_DATA, 8'd4);
		base = stepTotal;
		baseIn = stepInTotal;
		writeReg(ADDR_CMD_STATUS, CMD_SEEK);
		finishCommand();
		checkPulses("seek out step pulses", stepTotal - base, 1);
		checkPulses("seek out pulses with dirc high", stepInTotal - baseIn, 0);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'd4);
	endtask

	task automatic testRestore;
		int base;
		int baseIn;
		logic [7:0] v;
		@(posedge iCLK);
		#2;
		tr00 = 1'b0;
		base = stepTotal;
		baseIn = stepInTotal;
		writeReg(ADDR_CMD_STATUS, CMD_RESTORE);
		waitPulses(base, 2);
		@(posedge iCLK);
		#2;
		tr00 = 1'b1;	// Head arrives at track 0
		finishCommand();
		checkPulses("restore step pulses", stepTotal - base, 2);
		checkPulses("restore pulses with dirc high", stepInTotal - baseIn, 0);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'h00);
	endtask

	task automatic testStepAndUnload;
		int base;
		int baseIn;
		logic [7:0] v;
		@(posedge iCLK);
		#2;
		tr00 = 1'b0;
		base = stepTotal;
		baseIn = stepInTotal;
		writeReg(ADDR_CMD_STATUS,
			CMD_STEP_IN | (8'h1 << BIT_UPDATE) | (8'h1 << BIT_HEAD_LOAD));
		finishCommand();
		checkPulses("step in pulses", stepTotal - base, 1);
		checkPulses("step in pulses with dirc high", stepInTotal - baseIn, 1);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'd1);
		readReg(ADDR_CMD_STATUS, v);
		checkBit("status head loaded", v[STA_HEAD_LOADED], 1'b1);
		checkBit("hld", hld, 1'b1);
		@(posedge iCLK);
		#2;
		hrdy = 1'b0;	// Head loaded needs the drive's ready too
		repeat (3) @(posedge iCLK);
		readReg(ADDR_CMD_STATUS, v);
		checkBit("status head loaded without hrdy", v[STA_HEAD_LOADED], 1'b0);
		hrdy = 1'b1;
		base = stepTotal;
		baseIn = stepInTotal;
		writeReg(ADDR_CMD_STATUS, CMD_STEP_OUT | (8'h1 << BIT_HEAD_LOAD));
		finishCommand();
		checkPulses("step out pulses", stepTotal - base, 1);
		checkPulses("step out pulses with dirc high", stepInTotal - baseIn, 0);
		readReg(ADDR_TRACK, v);
		checkByte("trackReg", v, 8'd1);	// No update flag
		for (int i = 0; i < 15; i++) begin
			if (i == 14) begin
				checkBit("hld before last idle index", hld, 1'b1);
			end
			indexPulse();
		end
		repeat (2) @(posedge iCLK);
		#3;
		checkBit("hld after idle index pulses", hld, 1'b0);
	endtask

	task automatic testInterrupts;
		int base;
		logic [7:0] v;
		checkBit("intrq before status read", intrq, 1'b1);
		readStatus();
		@(posedge iCLK);
		#3;
		checkBit("intrq after status read", intrq, 1'b0);
		writeReg(ADDR_CMD_STATUS, CMD_FORCE_INT | 8'h08);
		@(posedge iCLK);
		#3;
		checkBit("intrq after force interrupt", intrq, 1'b1);
		writeReg(ADDR_DATA, 8'd40);
		base = stepTotal;
		writeReg(ADDR_CMD_STATUS, CMD_SEEK);
		waitPulses(base, 1);
		writeReg(ADDR_CMD_STATUS, CMD_FORCE_INT);
		base = stepTotal;
		readReg(ADDR_CMD_STATUS, v);
		checkBit("status busy after abort", v[STA_BUSY], 1'b0);
		checkBit("intrq after abort", intrq, 1'b0);
		// Longer than any step delay, so a missed abort shows a pulse
		repeat ((int'(RATE_TICKS_6) + int'(SETTLE_TICKS)) * (2 ** PRESCALE_BITS))
			@(posedge iCLK);
		#3;
		checkPulses("step pulses after abort", stepTotal - base, 0);
		checkBit("intrq after abort", intrq, 1'b0);
	endtask

	initial begin
		void'($urandom(32'h2e28));
		rstN = 1'b0;
		wrEn = 1'b0;
		adr = ADDR_CMD_STATUS;
		dataIn = '0;
		statusRead = 1'b0;
		hrdy = 1'b1;
		tr00 = 1'b1;
		ip = 1'b0;
		wrpt = 1'b1;
		testResetRestore();
		testRegisters();
		testSeek();
		testRestore();
		testStepAndUnload();
		testInterrupts();
		assertFails = UUT.uProps.widthFails + UUT.uProps.idleStepFails +
			UUT.uProps.resetIntFails;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checkTotal, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/fdcTop_props.sv
/*
 * Step pulse, busy and reset checks bound into the controller top level.
 */
`timescale 1ns/1ns
`default_nettype none

module fdcTop_props (
	input logic iCLK,
	input logic rstN,
	input logic step,
	input logic busy,
	input logic intrq
);
	import fdcTimingPkg::*;

	int highCycles;	// Edges with step seen high
	int widthFails = 0;
	int idleStepFails = 0;
	int resetIntFails = 0;

	always_ff @(posedge iCLK) begin
		if (!rstN) begin
			highCycles <= 0;
		end else if (step) begin
			highCycles <= highCycles + 1;
		end else begin
			highCycles <= 0;
		end
	end

	assert property (@(posedge iCLK) disable iff (!rstN)
		step |-> highCycles < STEP_PULSE_CYCLES)
		else begin
			$error("Step pulse longer than %0d cycles", STEP_PULSE_CYCLES);
			widthFails++;
		end

	assert property (@(posedge iCLK) disable iff (!rstN)
		$fell(step) |-> highCycles == STEP_PULSE_CYCLES)
		else begin
			$error("Step pulse shorter than %0d cycles", STEP_PULSE_CYCLES);
			widthFails++;
		end

	assert property (@(posedge iCLK) disable iff (!rstN) $rose(step) |-> busy)
		else begin
			$error("Step rose while the controller was idle");
			idleStepFails++;
		end

	assert property (@(posedge iCLK) !rstN |=> !intrq)
		else begin
			$error("INTRQ high in the cycle after reset");
			resetIntFails++;
		end

endmodule

`default_nettype wire

// File: vlog.f
source/fdcRegsPkg.sv
source/fdcTimingPkg.sv
source/driveSync.sv
source/stepTimer.sv
source/commandSequencer.sv
source/hostStatus.sv
source/fdcTop.sv
tests/fdcTop_props.sv
tests/fdcTb.sv
